/* rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int xlen = 32;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl     = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_jalr    = 3'b000;
    localparam logic [2:0] f3_word    = 3'b010; // LW and SW
    localparam logic [6:0] f7_base    = 7'b0000000;
    localparam logic [6:0] f7_alt     = 7'b0100000; // SUB

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [1:0] {
        wb_none = 2'd0,
        wb_alu  = 2'd1,
        wb_mem  = 2'd2,
        wb_link = 2'd3
    } wb_src_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_xor,
        alu_srl,
        alu_or,
        alu_and
    } alu_op_e;

endpackage

/* rv_pipe_pkg.sv */
package rv_pipe_pkg;
    import rv_isa_pkg::*;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
        alu_op_e         alu_op;
        logic            a_pc;   // Operand A from pc
        logic            a_zero; // Operand A forced to zero
        logic            b_imm;  // Operand B from immediate
        logic            branch;
        logic            branch_ne;
        logic            jal;
        logic            jalr;
        logic            mem_re;
        logic            mem_we;
        wb_src_e         wb_src;
    } dx_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        wb_src_e         wb_src;
        logic [xlen-1:0] alu_res;
        logic [xlen-1:0] link_val;
        logic [xlen-1:0] store_data;
        logic            mem_re;
        logic            mem_we;
    } xa_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        wb_src_e         wb_src;
        logic [xlen-1:0] result;
    } aw_t;

    typedef struct packed {
        logic            hit;
        logic [xlen-1:0] data;
    } fwd_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            we;
        logic            re;
    } dmem_req_t;

    // Value the access stage will hand to write-back
    function automatic logic [xlen-1:0] acc_result(input xa_t xa, input logic [xlen-1:0] rdata);
        case (xa.wb_src)
            wb_mem:  return rdata;
            wb_link: return xa.link_val;
            default: return xa.alu_res;
        endcase
    endfunction

endpackage

/* rv_regfile.sv */
module rv_regfile #(
    parameter int nregs = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rs1_val,
    output logic [31:0] rs2_val
);

    logic [31:0] regs [nregs];
    logic        wr_en;

    assign wr_en = we && (rd != 5'd0); // x0 is never written

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < nregs; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= wdata;
        end
    end

    // Write-first bypass
    assign rs1_val = (rs1 == 5'd0) ? '0 : (wr_en && rd == rs1) ? wdata : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : (wr_en && rd == rs2) ? wdata : regs[rs2];

endmodule

/* rv_decode.sv */
module rv_decode (
    input  rv_isa_pkg::instr_u instr,
    input  logic [31:0]        pc,
    input  logic               valid,
    input  logic [31:0]        rs1_val,
    input  logic [31:0]        rs2_val,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output rv_pipe_pkg::dx_t   dx
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        uses_rs1;
    logic        uses_rs2;
    alu_op_e     f3_op;
    logic        f3_ok;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;

    assign uses_rs1 = opcode inside {op_jalr, op_branch, op_load, op_store, op_imm, op_reg};
    assign uses_rs2 = opcode inside {op_branch, op_store, op_reg};
    assign rs1      = (valid && uses_rs1) ? instr.r.rs1 : 5'd0; // Zero keeps hazard check quiet
    assign rs2      = (valid && uses_rs2) ? instr.r.rs2 : 5'd0;

    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'd0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    // Shared by OP and OP-IMM; shifts only in their logical form
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            f3_add_sub: f3_op = alu_add;
            f3_sll:     f3_op = alu_sll;
            f3_slt:     f3_op = alu_slt;
            f3_xor:     f3_op = alu_xor;
            f3_srl:     f3_op = alu_srl;
            f3_or:      f3_op = alu_or;
            f3_and:     f3_op = alu_and;
            default: begin
                f3_op = alu_add;
                f3_ok = 1'b0;
            end
        endcase
        if ((funct3 == f3_sll || funct3 == f3_srl) && instr.r.funct7 != f7_base) begin
            f3_ok = 1'b0;
        end
    end

    always_comb begin
        dx         = '0;
        dx.valid   = valid;
        dx.pc      = pc;
        dx.rs1     = rs1;
        dx.rs2     = rs2;
        dx.rd      = instr.r.rd;
        dx.rs1_val = rs1_val;
        dx.rs2_val = rs2_val;
        dx.alu_op  = alu_add;
        dx.wb_src  = wb_none;
        case (opcode)
            op_lui: begin
                dx.imm    = imm_u;
                dx.a_zero = 1'b1;
                dx.b_imm  = 1'b1;
                dx.wb_src = wb_alu;
            end
            op_auipc: begin
                dx.imm    = imm_u;
                dx.a_pc   = 1'b1;
                dx.b_imm  = 1'b1;
                dx.wb_src = wb_alu;
            end
            op_jal: begin
                dx.imm    = imm_j;
                dx.jal    = 1'b1;
                dx.wb_src = wb_link;
            end
            op_jalr: begin
                dx.imm    = imm_i;
                dx.jalr   = (funct3 == f3_jalr);
                dx.wb_src = (funct3 == f3_jalr) ? wb_link : wb_none;
            end
            op_branch: begin
                dx.imm       = imm_b;
                dx.branch    = (funct3 == f3_beq) || (funct3 == f3_bne);
                dx.branch_ne = (funct3 == f3_bne);
            end
            op_load: begin
                dx.imm    = imm_i;
                dx.b_imm  = 1'b1;
                dx.mem_re = (funct3 == f3_word);
                dx.wb_src = (funct3 == f3_word) ? wb_mem : wb_none;
            end
            op_store: begin
                dx.imm    = imm_s;
                dx.b_imm  = 1'b1;
                dx.mem_we = (funct3 == f3_word);
            end
            op_imm: begin
                dx.imm    = imm_i;
                dx.b_imm  = 1'b1;
                dx.alu_op = f3_op;
                dx.wb_src = f3_ok ? wb_alu : wb_none;
            end
            op_reg: begin
                if (funct3 == f3_add_sub && instr.r.funct7 == f7_alt) begin
                    dx.alu_op = alu_sub;
                    dx.wb_src = wb_alu;
                end else begin
                    dx.alu_op = f3_op;
                    dx.wb_src = (f3_ok && instr.r.funct7 == f7_base) ? wb_alu : wb_none;
                end
            end
            default: ; // Unsupported opcode acts as a no-op
        endcase
    end

endmodule

/* rv_execute.sv */
module rv_execute (
    input  rv_pipe_pkg::dx_t dx,
    output rv_pipe_pkg::xa_t xa,
    output logic             redirect,
    output logic [31:0]      redirect_pc
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_res;
    logic            eq;
    logic            taken;
    logic [xlen-1:0] target_base;
    logic [xlen-1:0] target_sum;

    assign op_a  = dx.a_zero ? '0 : dx.a_pc ? dx.pc : dx.rs1_val;
    assign op_b  = dx.b_imm ? dx.imm : dx.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dx.alu_op)
            alu_sub: alu_res = op_a - op_b;
            alu_sll: alu_res = op_a << shamt;
            alu_srl: alu_res = op_a >> shamt;
            alu_slt: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_xor: alu_res = op_a ^ op_b;
            alu_or:  alu_res = op_a | op_b;
            alu_and: alu_res = op_a & op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    // Operands here already carry forwarded values
    assign eq    = (dx.rs1_val == dx.rs2_val);
    assign taken = (dx.branch && (eq ^ dx.branch_ne)) || dx.jal || dx.jalr;

    assign redirect    = dx.valid && taken;
    assign target_base = dx.jalr ? dx.rs1_val : dx.pc;
    assign target_sum  = target_base + dx.imm;
    assign redirect_pc = {target_sum[xlen-1:1], target_sum[0] & ~dx.jalr}; // JALR clears bit 0

    always_comb begin
        xa.valid      = dx.valid;
        xa.rd         = dx.rd;
        xa.wb_src     = dx.wb_src;
        xa.alu_res    = alu_res;
        xa.link_val   = dx.pc + 32'd4;
        xa.store_data = dx.rs2_val;
        xa.mem_re     = dx.mem_re;
        xa.mem_we     = dx.mem_we;
    end

endmodule

/* rv_hazard_unit.sv */
module rv_hazard_unit (
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  rv_pipe_pkg::dx_t dx,
    input  logic [31:0]      exe_alu_res,
    input  rv_pipe_pkg::xa_t xa,
    input  logic [31:0]      acc_rdata,
    input  rv_pipe_pkg::aw_t aw,
    output rv_pipe_pkg::fwd_t fwd_a,
    output rv_pipe_pkg::fwd_t fwd_b,
    output logic             stall
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [5:0]  conflict_map; // {wb_b, wb_a, acc_b, acc_a, exe_b, exe_a}
    logic [31:0] exe_data;
    logic [31:0] acc_data;
    logic        exe_is_load;

    function automatic logic candidate(input logic v, input wb_src_e src, input logic [4:0] rd,
                                       input logic [4:0] idx);
        return v && (src != wb_none) && (rd != 5'd0) && (rd == idx);
    endfunction

    // Youngest producer wins
    function automatic fwd_t pick(input logic hit_exe, input logic hit_acc, input logic hit_wb,
                                  input logic exe_load, input logic [31:0] d_exe,
                                  input logic [31:0] d_acc, input logic [31:0] d_wb);
        fwd_t f;
        f = '0;
        if (hit_exe) begin
            f.hit  = !exe_load; // Load data not ready yet so stall instead
            f.data = d_exe;
        end else if (hit_acc) begin
            f.hit  = 1'b1;
            f.data = d_acc;
        end else if (hit_wb) begin
            f.hit  = 1'b1;
            f.data = d_wb;
        end
        return f;
    endfunction

    assign exe_is_load = (dx.wb_src == wb_mem);
    assign exe_data    = (dx.wb_src == wb_link) ? dx.pc + 32'd4 : exe_alu_res;
    assign acc_data    = acc_result(xa, acc_rdata);

    always_comb begin
        conflict_map[0] = candidate(dx.valid, dx.wb_src, dx.rd, rs1);
        conflict_map[1] = candidate(dx.valid, dx.wb_src, dx.rd, rs2);
        conflict_map[2] = candidate(xa.valid, xa.wb_src, xa.rd, rs1);
        conflict_map[3] = candidate(xa.valid, xa.wb_src, xa.rd, rs2);
        conflict_map[4] = candidate(aw.valid, aw.wb_src, aw.rd, rs1);
        conflict_map[5] = candidate(aw.valid, aw.wb_src, aw.rd, rs2);
    end

    assign stall = exe_is_load && (conflict_map[0] || conflict_map[1]);

    assign fwd_a = pick(conflict_map[0], conflict_map[2], conflict_map[4], exe_is_load,
                        exe_data, acc_data, aw.result);
    assign fwd_b = pick(conflict_map[1], conflict_map[3], conflict_map[5], exe_is_load,
                        exe_data, acc_data, aw.result);

endmodule

/* rv_core_top.sv */
module rv_core_top #(
    parameter logic [31:0] reset_pc = 32'h0,
    parameter int          nregs    = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic [31:0]            imem_addr,
    input  logic [31:0]            imem_data,
    output rv_pipe_pkg::dmem_req_t dmem_req,
    input  logic [31:0]            dmem_rdata
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [31:0] pc;
    logic        fd_valid;
    logic [31:0] fd_pc;
    instr_u      fd_instr;
    dx_t         dx_dec;
    dx_t         dx_fwd;
    dx_t         dx_q;
    xa_t         xa_next;
    xa_t         xa_q;
    aw_t         aw_next;
    aw_t         aw_q;
    logic [4:0]  dec_rs1;
    logic [4:0]  dec_rs2;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    fwd_t        fwd_a;
    fwd_t        fwd_b;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        wb_we;

    assign imem_addr = pc;

    rv_regfile #(.nregs(nregs)) u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .rd      (aw_q.rd),
        .we      (wb_we),
        .wdata   (aw_q.result),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    rv_decode u_decode (
        .instr   (fd_instr),
        .pc      (fd_pc),
        .valid   (fd_valid),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .dx      (dx_dec)
    );

    rv_hazard_unit u_hazard (
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .dx          (dx_q),
        .exe_alu_res (xa_next.alu_res),
        .xa          (xa_q),
        .acc_rdata   (dmem_rdata),
        .aw          (aw_q),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .stall       (stall)
    );

    rv_execute u_execute (
        .dx          (dx_q),
        .xa          (xa_next),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    always_comb begin
        dx_fwd = dx_dec;
        if (fwd_a.hit) dx_fwd.rs1_val = fwd_a.data;
        if (fwd_b.hit) dx_fwd.rs2_val = fwd_b.data;
    end

    // Access stage
    assign dmem_req.addr  = xa_q.alu_res;
    assign dmem_req.wdata = xa_q.store_data;
    assign dmem_req.we    = xa_q.valid && xa_q.mem_we;
    assign dmem_req.re    = xa_q.valid && xa_q.mem_re;

    assign aw_next = '{valid: xa_q.valid, rd: xa_q.rd, wb_src: xa_q.wb_src,
                       result: acc_result(xa_q, dmem_rdata)};

    assign wb_we = aw_q.valid && (aw_q.wb_src != wb_none);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= reset_pc;
            fd_valid <= 1'b0;
            dx_q     <= '0;
            xa_q     <= '0;
            aw_q     <= '0;
        end else begin
            if (redirect) begin
                pc       <= redirect_pc;
                fd_valid <= 1'b0; // Redirect overrides any stall
            end else if (!stall) begin
                pc       <= pc + 32'd4;
                fd_valid <= 1'b1;
            end
            dx_q <= dx_fwd;
            if (redirect || stall) dx_q.valid <= 1'b0; // Bubble
            xa_q <= xa_next;
            aw_q <= aw_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall || redirect) begin
            fd_pc    <= pc;
            fd_instr <= imem_data;
        end
    end

endmodule

/* tb_rv_model.svh */
`ifndef tb_rv_model_svh
`define tb_rv_model_svh

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
endfunction

function automatic logic [31:0] reg_op(input logic [2:0] f3, input logic alt,
                                       input logic [4:0] rd, rs1, rs2);
    return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] load_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

function automatic logic [31:0] store_word(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] branch_to(input logic ne, input logic [4:0] rs1, rs2,
                                          input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] jump_link(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] jump_reg(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b1100111};
endfunction

function automatic logic [31:0] upper_imm(input logic aui, input logic [4:0] rd,
                                          input logic [19:0] imm);
    return {imm, rd, aui ? 7'b0010111 : 7'b0110111};
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'd0, $signed(a) < $signed(b)};
        3'd4: return a ^ b;
        3'd5: return a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// Architectural run of the loaded program; collects the stores in order
task automatic run_model();
    logic [31:0] x [32];
    logic [31:0] mem [256];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] nxt;
    logic [31:0] addr;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        wr;
    int          steps;
    for (int k = 0; k < 32; k++) begin
        x[k] = '0;
    end
    for (int k = 0; k < 256; k++) begin
        mem[k] = init_mem[k];
    end
    exp_addr.delete();
    exp_data.delete();
    pc = '0;
    steps = 0;
    while (imem[pc[9:2]] != jal_self && steps < 5000) begin
        ins   = imem[pc[9:2]];
        a     = x[ins[19:15]];
        b     = x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'd0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = pc + 32'd4;
        wr    = 1'b1;
        res   = '0;
        case (ins[6:0])
            7'b0110111: res = imm_u;
            7'b0010111: res = pc + imm_u;
            7'b1101111: begin
                res = pc + 32'd4;
                nxt = pc + imm_j;
            end
            7'b1100111: begin
                res = pc + 32'd4;
                nxt = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                if ((a == b) != ins[12]) nxt = pc + imm_b; // BEQ when bit 12 clear
            end
            7'b0000011: begin
                addr = a + imm_i;
                res  = mem[addr[9:2]];
            end
            7'b0100011: begin
                wr   = 1'b0;
                addr = a + imm_s;
                mem[addr[9:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end
            7'b0010011: res = alu_ref(ins[14:12], 1'b0, a, imm_i);
            7'b0110011: res = alu_ref(ins[14:12], ins[30], a, b);
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
        pc = nxt;
        steps++;
    end
endtask

`endif

/* tb_rv_core.sv */
module tb_rv_core;
    import rv_pipe_pkg::*;

    localparam logic [31:0] jal_self = 32'h0000_006f;
    localparam int max_words = 256;
    localparam int n_progs = 6;
    localparam int watchdog_cycles = n_progs * (20 * max_words + 50 + 30);

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] init_mem [256];
    logic [31:0] prog [256];
    int          prog_len = 0;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] rng;
    int          st_idx = 0;
    int          errors = 0;
    int          extra_stores = 0;
    int          timeouts = 0;

    `include "tb_rv_model.svh"

    rv_core_top #(.reset_pc(32'h0), .nregs(32)) UUT (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    always #4 clk = ~clk;

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_req.re ? dmem[dmem_req.addr[9:2]] : 'x; // Only valid on a read

    always @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 256; k++) begin
                dmem[k] <= init_mem[k]; // Reload the image for each program
            end
        end else if (dmem_req.we) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    // Store checker
    always @(posedge clk) begin
        if (rst) begin
            st_idx <= 0;
        end else if (dmem_req.we) begin
            assert (st_idx < exp_addr.size()) else begin
                $display("Unexpected store at time %0t to address %h after all %0d expected stores",
                         $time, dmem_req.addr, exp_addr.size());
                extra_stores <= extra_stores + 1;
            end
            if (st_idx < exp_addr.size()) begin
                assert (dmem_req.addr == exp_addr[st_idx] && dmem_req.wdata == exp_data[st_idx])
                else begin
                    $display("ERROR %0t: store %0d expected [%h]=%h, got [%h]=%h", $time, st_idx,
                             exp_addr[st_idx], exp_data[st_idx], dmem_req.addr, dmem_req.wdata);
                    errors <= errors + 1;
                end
                st_idx <= st_idx + 1;
            end
        end
    end

    function automatic void emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    task automatic run_program(input string name);
        int limit;
        int cycles;
        @(posedge clk);
        #1 rst = 1'b1;
        for (int k = 0; k < 256; k++) begin
            imem[k]     = (k < prog_len) ? prog[k] : jal_self;
            init_mem[k] = 32'h3c00_0000 ^ (k * 32'h0004_0081);
        end
        run_model();
        limit = 20 * prog_len + 50;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        cycles = 0;
        while (st_idx < exp_addr.size() && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (st_idx < exp_addr.size()) begin
            $display("%s: timed out waiting for stores, %0d of %0d seen", name, st_idx,
                     exp_addr.size());
            timeouts++;
        end
        repeat (20) @(posedge clk); // Catch stray stores
        prog_len = 0;
    endtask

    task automatic chain_program();
        emit(imm_op(3'd0, 5'd1, 5'd0, 12'd5));
        emit(imm_op(3'd0, 5'd2, 5'd1, 12'd3));    // Distance 1
        emit(imm_op(3'd0, 5'd3, 5'd1, 12'd7));    // Distance 2
        emit(imm_op(3'd0, 5'd4, 5'd1, 12'd1));    // Distance 3
        emit(store_word(5'd2, 5'd0, 12'd0));
        emit(store_word(5'd3, 5'd0, 12'd4));
        emit(store_word(5'd4, 5'd0, 12'd8));
        emit(imm_op(3'd0, 5'd5, 5'd0, 12'd1));
        emit(imm_op(3'd0, 5'd5, 5'd5, 12'd2));
        emit(reg_op(3'd0, 1'b0, 5'd6, 5'd5, 5'd5)); // Youngest x5 must win
        emit(store_word(5'd6, 5'd0, 12'd12));
        emit(upper_imm(1'b0, 5'd7, 20'h12345));
        emit(reg_op(3'd0, 1'b1, 5'd8, 5'd7, 5'd6));
        emit(reg_op(3'd1, 1'b0, 5'd9, 5'd8, 5'd2));
        emit(reg_op(3'd5, 1'b0, 5'd10, 5'd9, 5'd3));
        emit(reg_op(3'd2, 1'b0, 5'd11, 5'd10, 5'd8));
        emit(store_word(5'd8, 5'd0, 12'd16));
        emit(store_word(5'd9, 5'd0, 12'd20));
        emit(store_word(5'd10, 5'd0, 12'd24));
        emit(store_word(5'd11, 5'd0, 12'd28));
        emit(imm_op(3'd4, 5'd12, 5'd10, 12'hfff));
        emit(reg_op(3'd6, 1'b0, 5'd13, 5'd12, 5'd4));
        emit(reg_op(3'd7, 1'b0, 5'd14, 5'd13, 5'd7));
        emit(reg_op(3'd4, 1'b0, 5'd15, 5'd14, 5'd13));
        emit(upper_imm(1'b1, 5'd16, 20'h00010));
        emit(imm_op(3'd0, 5'd17, 5'd0, 12'd64));
        emit(store_word(5'd15, 5'd17, 12'd0));   // Base from execute stage
        emit(store_word(5'd16, 5'd17, 12'd4));
        emit(imm_op(3'd1, 5'd18, 5'd16, 12'd4));
        emit(imm_op(3'd2, 5'd19, 5'd12, 12'd0));
        emit(store_word(5'd18, 5'd0, 12'd72));
        emit(store_word(5'd19, 5'd0, 12'd76));
    endtask

    task automatic load_use_program();
        emit(load_word(5'd1, 5'd0, 12'd16));
        emit(reg_op(3'd0, 1'b0, 5'd2, 5'd1, 5'd1)); // Needs the load right away
        emit(store_word(5'd2, 5'd0, 12'd0));
        emit(load_word(5'd3, 5'd0, 12'd20));
        emit(store_word(5'd3, 5'd0, 12'd4));      // Store data from the load
        emit(imm_op(3'd0, 5'd5, 5'd0, 12'd64));
        emit(load_word(5'd6, 5'd0, 12'd28));
        emit(store_word(5'd6, 5'd5, 12'd0));
        emit(load_word(5'd7, 5'd0, 12'd8));
        emit(imm_op(3'd0, 5'd0, 5'd0, 12'd0));
        emit(reg_op(3'd4, 1'b0, 5'd8, 5'd7, 5'd6));
        emit(store_word(5'd8, 5'd0, 12'd8));
        emit(load_word(5'd9, 5'd0, 12'd4));       // Reads the word stored above
        emit(imm_op(3'd0, 5'd10, 5'd9, 12'd1));
        emit(store_word(5'd10, 5'd0, 12'd12));
    endtask

    task automatic jump_program();
        emit(jump_link(5'd1, 21'd12));            // 0 to 12
        emit(store_word(5'd1, 5'd0, 12'd32));
        emit(store_word(5'd1, 5'd0, 12'd36));
        emit(store_word(5'd1, 5'd0, 12'd0));
        emit(imm_op(3'd0, 5'd2, 5'd0, 12'd41));
        emit(jump_reg(5'd3, 5'd2, 12'd0));        // 20 to 40 with bit 0 dropped
        emit(store_word(5'd3, 5'd0, 12'd40));
        emit(store_word(5'd3, 5'd0, 12'd44));
        emit(store_word(5'd2, 5'd0, 12'd48));
        emit(store_word(5'd2, 5'd0, 12'd52));
        emit(imm_op(3'd0, 5'd4, 5'd3, 12'd1));
        emit(store_word(5'd3, 5'd0, 12'd4));
        emit(store_word(5'd4, 5'd0, 12'd8));
        emit(jump_link(5'd7, 21'd12));            // 52 to 64
        emit(store_word(5'd7, 5'd0, 12'd56));
        emit(store_word(5'd7, 5'd0, 12'd60));
        emit(store_word(5'd7, 5'd0, 12'd12));
    endtask

    task automatic branch_program();
        emit(imm_op(3'd0, 5'd1, 5'd0, 12'd7));
        emit(imm_op(3'd0, 5'd2, 5'd0, 12'd7));
        emit(branch_to(1'b0, 5'd1, 5'd2, 13'd12)); // Taken
        emit(store_word(5'd1, 5'd0, 12'd0));
        emit(store_word(5'd1, 5'd0, 12'd4));
        emit(branch_to(1'b1, 5'd1, 5'd2, 13'd12)); // Not taken
        emit(store_word(5'd2, 5'd0, 12'd8));
        emit(imm_op(3'd0, 5'd3, 5'd0, 12'd9));
        emit(branch_to(1'b1, 5'd3, 5'd1, 13'd12)); // Taken
        emit(store_word(5'd3, 5'd0, 12'd12));
        emit(store_word(5'd3, 5'd0, 12'd16));
        emit(branch_to(1'b0, 5'd3, 5'd1, 13'd8));  // Not taken
        emit(store_word(5'd3, 5'd0, 12'd20));
        emit(store_word(5'd1, 5'd0, 12'd24));
    endtask

    task automatic zero_reg_program();
        emit(imm_op(3'd0, 5'd0, 5'd0, 12'd5));
        emit(store_word(5'd0, 5'd0, 12'd0));
        emit(upper_imm(1'b0, 5'd0, 20'habcde));
        emit(reg_op(3'd0, 1'b0, 5'd1, 5'd0, 5'd0));
        emit(store_word(5'd1, 5'd0, 12'd4));
        emit(load_word(5'd0, 5'd0, 12'd8));
        emit(store_word(5'd0, 5'd0, 12'd12));
        emit(jump_link(5'd0, 21'd8));
        emit(store_word(5'd1, 5'd0, 12'd20));
        emit(store_word(5'd0, 5'd0, 12'd16));
    endtask

    task automatic random_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        for (int i = 0; i < 200; i++) begin
            r   = rand_word();
            rd  = {2'b00, r[2:0]}; // Few registers keep hazards frequent
            rs1 = {2'b00, r[5:3]};
            rs2 = {2'b00, r[8:6]};
            f3  = (r[11:9] == 3'd3) ? 3'd0 : r[11:9];
            if (i % 10 == 9) begin
                emit(store_word(rs2, 5'd0, {2'b00, r[17:10], 2'b00}));
            end else begin
                case (r[31:29])
                    3'd0: emit(upper_imm(1'b0, rd, r[27:8]));
                    3'd1: emit(upper_imm(1'b1, rd, r[27:8]));
                    3'd2, 3'd3: begin
                        if (f3 == 3'd1 || f3 == 3'd5) emit(imm_op(f3, rd, rs1, {7'd0, r[16:12]}));
                        else emit(imm_op(f3, rd, rs1, r[23:12]));
                    end
                    3'd4: emit(reg_op(f3, (f3 == 3'd0) && r[24], rd, rs1, rs2));
                    3'd5: emit(load_word(rd, 5'd0, {2'b00, r[19:12], 2'b00}));
                    3'd6: begin
                        if (i < 198) emit(branch_to(r[25], rs1, rs2, 13'd8));
                        else emit(imm_op(3'd0, rd, rs1, 12'd1));
                    end
                    default: begin
                        if (i < 198) emit(jump_link(rd, 21'd8));
                        else emit(imm_op(3'd0, rd, rs1, 12'd1));
                    end
                endcase
            end
        end
    endtask

    initial begin
        #(watchdog_cycles * 8);
        $display("Watchdog expired before all programs finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rng = 32'd30712;
        chain_program();
        run_program("dependent chains");
        load_use_program();
        run_program("load use");
        jump_program();
        run_program("jumps");
        branch_program();
        run_program("branches");
        zero_reg_program();
        run_program("x0 writes");
        random_program();
        run_program("random program");
        $display("Store errors: %0d, other failures: %0d", errors, extra_stores + timeouts);
        if (errors == 0 && extra_stores == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_hazard_unit.sv
rv_core_top.sv
tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_rv_core
out=$(./obj_dir/Vtb_rv_core)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
